// File: pmu_top.f
+incdir+.
pmu_pkg.sv
pmu_regs.sv
pmu_event_select.sv
pmu_counters.sv
pmu_overflow.sv
pmu_quota.sv
pmu_top.sv
pmu_top_asserts.sv
tb_pmu_top.sv

// File: Makefile
TOOL      := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_pmu_top
LINT_TOP  := pmu_top
FILELIST  := pmu_top.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_TEXT := Errors found

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_pmu_top.sv
// PMU testbench; counting tests come from a table, overflow and quota are directed sequences
`default_nettype none
`timescale 1ns/1ps

`include "pmu_defines.svh"

module tb_pmu_top;

    localparam int CLK_PERIOD    = 10;
    localparam int NUM_TESTS     = 7;
    // Setup, drain and readback around each window
    localparam int TEST_OVERHEAD = 30;
    // Reset, overflow and quota sequences
    localparam int MARGIN_CYCLES = 400;
    localparam logic [31:0] CFG_EN            = 32'd1 << `PMU_CFG_EN_BIT;
    localparam logic [31:0] CFG_SOFTRST       = 32'd1 << `PMU_CFG_SOFTRST_BIT;
    localparam logic [31:0] CFG_OVF_EN        = 32'd1 << `PMU_CFG_OVF_EN_BIT;
    localparam logic [31:0] CFG_OVF_SOFTRST   = 32'd1 << `PMU_CFG_OVF_SOFTRST_BIT;
    localparam logic [31:0] CFG_QUOTA_SOFTRST = 32'd1 << `PMU_CFG_QUOTA_SOFTRST_BIT;

    logic                       clk_i;
    logic                       rstn_i;
    pmu_pkg::soc_events_t       events_i;
    logic                       reg_we_i;
    logic [`PMU_ADDR_WIDTH-1:0] reg_addr_i;
    pmu_pkg::reg_word_t         reg_wdata_i;
    pmu_pkg::reg_word_t         reg_rdata_o;
    logic                       intr_overflow_o;
    logic                       intr_quota_o;

    // ------------------------------
    // Counting test table
    // ------------------------------
    string              tab_name    [NUM_TESTS];
    pmu_pkg::selftest_e tab_mode    [NUM_TESTS];
    logic [31:0]        tab_xbar    [NUM_TESTS];
    logic [15:0]        tab_events  [NUM_TESTS];
    // Random selects and events, expected counts built while driving
    bit                 tab_rnd     [NUM_TESTS];
    int                 tab_cycles  [NUM_TESTS];
    // Counters that gain the full window
    logic [7:0]         tab_exp_hit [NUM_TESTS];
    int                 tab_count;
    bit                 table_ready;

    int          errors;
    int          tests_run;
    int          tests_failed;
    int          err_mark;
    logic [31:0] quota_loads [`PMU_N_COUNTERS];

    pmu_top pmu_top_inst (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .events_i        (events_i),
        .reg_we_i        (reg_we_i),
        .reg_addr_i      (reg_addr_i),
        .reg_wdata_i     (reg_wdata_i),
        .reg_rdata_o     (reg_rdata_o),
        .intr_overflow_o (intr_overflow_o),
        .intr_quota_o    (intr_quota_o)
    );

    bind pmu_top pmu_top_asserts pmu_top_asserts_inst (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .ovf_en_i        (ovf_en),
        .reg_rdata_i     (reg_rdata_o),
        .intr_overflow_i (intr_overflow_o),
        .intr_quota_i    (intr_quota_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic add_test(input string name, input pmu_pkg::selftest_e mode,
                            input logic [31:0] xbar, input logic [15:0] events,
                            input bit rnd, input int cycles, input logic [7:0] exp_hit);
        tab_name[tab_count]    = name;
        tab_mode[tab_count]    = mode;
        tab_xbar[tab_count]    = xbar;
        tab_events[tab_count]  = events;
        tab_rnd[tab_count]     = rnd;
        tab_cycles[tab_count]  = cycles;
        tab_exp_hit[tab_count] = exp_hit;
        tab_count++;
    endtask

    task automatic fill_table();
        tab_count = 0;
        // Identity selects, counter k sees line k
        add_test("xbar_fixed", pmu_pkg::NO_SELF_TEST, 32'h7654_3210, 16'h00A5, 1'b0, 5, 8'hA5);
        // Counter k sees line k+8
        add_test("xbar_upper", pmu_pkg::NO_SELF_TEST, 32'hFEDC_BA98, 16'h3C00, 1'b0, 7, 8'h3C);
        add_test("xbar_rand_a", pmu_pkg::NO_SELF_TEST, 32'h0, 16'h0, 1'b1, 20, 8'h00);
        add_test("xbar_rand_b", pmu_pkg::NO_SELF_TEST, 32'h0, 16'h0, 1'b1, 33, 8'h00);
        add_test("st_all_active", pmu_pkg::ALL_ACTIVE, 32'h0, 16'h0000, 1'b0, 9, 8'hFF);
        // Lines all high, override must win
        add_test("st_all_off", pmu_pkg::ALL_OFF, 32'h0, 16'hFFFF, 1'b0, 6, 8'h00);
        add_test("st_one_on", pmu_pkg::ONE_ON, 32'h0, 16'hFFFF, 1'b0, 11, 8'h01);
    endtask

    // Caller sits just after a falling edge, so does the task on return
    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        reg_we_i    = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        @(negedge clk_i);
        reg_we_i    = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
        reg_addr_i = addr;
        #1;
        data = reg_rdata_o;
        @(negedge clk_i);
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk_i);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d mismatches", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // Masked sum at full width, strictly above the limit
    function automatic logic [31:0] quota_expect(input logic [7:0] mask, input logic [31:0] limit);
        logic [63:0] total;
        total = 64'd0;
        for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
            if (mask[k]) begin
                total += {32'd0, quota_loads[k]};
            end
        end
        return (total > {32'd0, limit}) ? 32'd1 : 32'd0;
    endfunction

    task automatic test_reset();
        logic [31:0] rdata;
        for (int a = 0; a < (1 << `PMU_ADDR_WIDTH); a++) begin
            read_reg(4'(a), rdata);
            check_value($sformatf("reset addr%0d", a), 32'd0, rdata);
        end
        check_value("reset intr_overflow", 32'd0, 32'(intr_overflow_o));
        check_value("reset intr_quota", 32'd0, 32'(intr_quota_o));
        finish_test("reset");
    endtask

    task automatic run_table_test(input int t);
        logic [31:0] mode_word;
        logic [31:0] xbar;
        logic [31:0] rdata;
        int          expected [`PMU_N_COUNTERS];
        mode_word = 32'(tab_mode[t]) << `PMU_CFG_SELFTEST_LSB;
        xbar      = tab_rnd[t] ? $urandom : tab_xbar[t];
        events_i  = tab_rnd[t] ? 16'h0000 : tab_events[t];
        for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
            expected[k] = 0;
        end
        // Clear counters with the mode already applied
        write_reg(`PMU_ADDR_XBAR, xbar);
        write_reg(`PMU_ADDR_CFG, mode_word | CFG_SOFTRST);
        write_reg(`PMU_ADDR_CFG, mode_word);
        idle(2);
        write_reg(`PMU_ADDR_CFG, mode_word | CFG_EN);
        if (tab_rnd[t]) begin
            // One random pattern per cycle, counted on the selected line
            for (int i = 0; i < tab_cycles[t]; i++) begin
                events_i = pmu_pkg::soc_events_t'($urandom);
                for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
                    if (events_i[xbar[k*`PMU_SEL_BITS +: `PMU_SEL_BITS]]) begin
                        expected[k]++;
                    end
                end
                @(negedge clk_i);
            end
            events_i = 16'h0000;
            // Enable drops two cycles after the last pattern
            @(negedge clk_i);
            write_reg(`PMU_ADDR_CFG, mode_word);
        end else begin
            // Enable seen on exactly tab_cycles rising edges
            idle(tab_cycles[t] - 1);
            write_reg(`PMU_ADDR_CFG, mode_word);
            for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
                expected[k] = tab_exp_hit[t][k] ? tab_cycles[t] : 0;
            end
        end
        events_i = 16'h0000;
        idle(2);
        read_reg(`PMU_ADDR_XBAR, rdata);
        check_value($sformatf("%s xbar", tab_name[t]), xbar, rdata);
        for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
            read_reg(4'(`PMU_ADDR_CNT_BASE + k), rdata);
            check_value($sformatf("%s cnt%0d", tab_name[t], k), 32'(expected[k]), rdata);
        end
        finish_test(tab_name[t]);
    endtask

    task automatic test_overflow();
        logic [31:0] rdata;
        // Counter 3 listens to line 5 only
        write_reg(`PMU_ADDR_XBAR, 32'h0000_5000);
        write_reg(`PMU_ADDR_CFG, CFG_SOFTRST);
        write_reg(`PMU_ADDR_CFG, 32'd0);
        write_reg(4'(`PMU_ADDR_CNT_BASE + 3), 32'hFFFF_FFFE);
        read_reg(4'(`PMU_ADDR_CNT_BASE + 3), rdata);
        check_value("overflow load", 32'hFFFF_FFFE, rdata);
        write_reg(`PMU_ADDR_OVF_MASK, 32'd0);
        write_reg(`PMU_ADDR_CFG, CFG_EN | CFG_OVF_EN);
        // Three events step through all ones, zero, one
        events_i = 16'h0020;
        idle(3);
        events_i = 16'h0000;
        idle(3);
        read_reg(4'(`PMU_ADDR_CNT_BASE + 3), rdata);
        check_value("overflow count", 32'hFFFF_FFFE + 32'd3, rdata);
        read_reg(`PMU_ADDR_OVF_VECT, rdata);
        check_value("overflow vector", 32'd1 << 3, rdata);
        check_value("overflow masked", 32'd0, 32'(intr_overflow_o));
        write_reg(`PMU_ADDR_OVF_MASK, 32'd1 << 3);
        check_value("overflow unmasked", 32'd1, 32'(intr_overflow_o));
        write_reg(`PMU_ADDR_CFG, CFG_EN);
        check_value("overflow disabled", 32'd0, 32'(intr_overflow_o));
        write_reg(`PMU_ADDR_CFG, CFG_EN | CFG_OVF_EN);
        check_value("overflow enabled", 32'd1, 32'(intr_overflow_o));
        // Vector clears one edge after the soft reset lands
        write_reg(`PMU_ADDR_CFG, CFG_OVF_EN | CFG_OVF_SOFTRST);
        idle(1);
        read_reg(`PMU_ADDR_OVF_VECT, rdata);
        check_value("overflow softrst vector", 32'd0, rdata);
        check_value("overflow softrst intr", 32'd0, 32'(intr_overflow_o));
        write_reg(`PMU_ADDR_CFG, 32'd0);
        finish_test("overflow");
    endtask

    task automatic test_quota();
        logic [7:0]  masks  [6];
        logic [31:0] limits [6];
        masks  = '{8'h03, 8'h03, 8'h05, 8'h20, 8'h00, 8'hFF};
        limits = '{32'd299, 32'd300, 32'hFFFF_FFFF, 32'd49, 32'd0, 32'hFFFF_FFFF};
        // Counter 2 plus counter 0 goes past 32 bits
        quota_loads = '{32'd100, 32'd200, 32'hFFFF_FFF0, 32'd7,
                        32'd0, 32'd50, 32'd1000, 32'hFFFF_FFFF};
        write_reg(`PMU_ADDR_CFG, CFG_SOFTRST);
        write_reg(`PMU_ADDR_CFG, 32'd0);
        for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
            write_reg(4'(`PMU_ADDR_CNT_BASE + k), quota_loads[k]);
        end
        for (int c = 0; c < 6; c++) begin
            write_reg(`PMU_ADDR_QUOTA_MASK, 32'(masks[c]));
            write_reg(`PMU_ADDR_QUOTA_LIMIT, limits[c]);
            idle(3);
            check_value($sformatf("quota case%0d", c), quota_expect(masks[c], limits[c]),
                        32'(intr_quota_o));
        end
        // Last case sits above its limit
        write_reg(`PMU_ADDR_CFG, CFG_QUOTA_SOFTRST);
        idle(2);
        check_value("quota softrst", 32'd0, 32'(intr_quota_o));
        write_reg(`PMU_ADDR_CFG, 32'd0);
        idle(3);
        check_value("quota release", quota_expect(masks[5], limits[5]), 32'(intr_quota_o));
        finish_test("quota");
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        rstn_i       = 1'b0;
        events_i     = 16'h0000;
        reg_we_i     = 1'b0;
        reg_addr_i   = '0;
        reg_wdata_i  = 32'd0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        err_mark     = 0;
        void'($urandom(52781));
        fill_table();
        table_ready  = 1'b1;
        repeat (2) @(negedge clk_i);
        rstn_i = 1'b1;
        test_reset();
        for (int t = 0; t < tab_count; t++) begin
            run_table_test(t);
        end
        write_reg(`PMU_ADDR_CFG, 32'd0);
        test_overflow();
        test_quota();
        $display("Summary: %0d tests, %0d failed, %0d mismatches",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog sized from the longest table entry
    initial begin
        int longest;
        int limit_cycles;
        wait (table_ready);
        longest = 0;
        for (int t = 0; t < tab_count; t++) begin
            if (tab_cycles[t] > longest) begin
                longest = tab_cycles[t];
            end
        end
        limit_cycles = tab_count * (longest + TEST_OVERHEAD) + MARGIN_CYCLES;
        #(limit_cycles * CLK_PERIOD);
        $display("Timeout: run still going after %0d clock cycles", limit_cycles);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: pmu_top_asserts.sv
// PMU top-level checks; bound to pmu_top, needs the internal overflow enable wire ovf_en
`default_nettype none
`timescale 1ns/1ps

module pmu_top_asserts (
    input wire                     clk_i,
    input wire                     rstn_i,
    input wire                     ovf_en_i,
    input wire pmu_pkg::reg_word_t reg_rdata_i,
    input wire                     intr_overflow_i,
    input wire                     intr_quota_i
);

    // ------------------------------
    // Reset release
    // ------------------------------
    // Both interrupts quiet on the first edge out of reset
    a_intr_low_after_reset: assert property (
        @(posedge clk_i) $rose(rstn_i) |-> (!intr_overflow_i && !intr_quota_i)
    ) else $error("Interrupt high on the first edge after reset release");

    // ------------------------------
    // Steady-state rules
    // ------------------------------
    // Overflow interrupt gated by its enable
    a_ovf_needs_enable: assert property (
        @(posedge clk_i) disable iff (!rstn_i) !ovf_en_i |-> !intr_overflow_i
    ) else $error("Overflow interrupt high while overflow enable is clear");

    // Outputs always driven to known levels
    a_outputs_known: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
            !$isunknown({reg_rdata_i, intr_overflow_i, intr_quota_i})
    ) else $error("Unknown value on a PMU output");

endmodule

`default_nettype wire

// File: pmu_top.sv
// PMU top; software port is a bare write strobe plus combinational read, no back-pressure
`default_nettype none
`timescale 1ns/1ps

`include "pmu_defines.svh"

module pmu_top (
    input  wire                          clk_i,
    input  wire                          rstn_i,
    input  wire pmu_pkg::soc_events_t    events_i,
    input  wire                          reg_we_i,
    input  wire [`PMU_ADDR_WIDTH-1:0]    reg_addr_i,
    input  wire pmu_pkg::reg_word_t      reg_wdata_i,
    output pmu_pkg::reg_word_t           reg_rdata_o,
    output logic                         intr_overflow_o,
    output logic                         intr_quota_o
);

    // ------------------------------
    // Config and status wires
    // ------------------------------
    logic                                 cnt_en;
    logic                                 cnt_softrst;
    logic                                 ovf_en;
    logic                                 ovf_softrst;
    logic                                 quota_softrst;
    pmu_pkg::selftest_e                   selftest;
    pmu_pkg::counter_mask_t               ovf_mask;
    pmu_pkg::counter_mask_t               quota_mask;
    pmu_pkg::reg_word_t                   quota_limit;
    pmu_pkg::xbar_sel_t                   xbar_sel [`PMU_N_COUNTERS];
    logic                                 cnt_load;
    logic [$clog2(`PMU_N_COUNTERS)-1:0]   cnt_load_idx;
    pmu_pkg::reg_word_t                   cnt_load_val;
    // Datapath back to software
    pmu_pkg::counter_mask_t               cnt_events;
    pmu_pkg::counter_array_t              cnt_values;
    pmu_pkg::counter_mask_t               wrap;
    pmu_pkg::counter_mask_t               ovf_vect;

    pmu_regs pmu_regs_inst (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .reg_we_i        (reg_we_i),
        .reg_addr_i      (reg_addr_i),
        .reg_wdata_i     (reg_wdata_i),
        .cnt_values_i    (cnt_values),
        .ovf_vect_i      (ovf_vect),
        .reg_rdata_o     (reg_rdata_o),
        .cnt_en_o        (cnt_en),
        .cnt_softrst_o   (cnt_softrst),
        .ovf_en_o        (ovf_en),
        .ovf_softrst_o   (ovf_softrst),
        .quota_softrst_o (quota_softrst),
        .selftest_o      (selftest),
        .ovf_mask_o      (ovf_mask),
        .quota_mask_o    (quota_mask),
        .quota_limit_o   (quota_limit),
        .xbar_sel_o      (xbar_sel),
        .cnt_load_o      (cnt_load),
        .cnt_load_idx_o  (cnt_load_idx),
        .cnt_load_val_o  (cnt_load_val)
    );

    // Registered routing stage
    pmu_event_select pmu_event_select_inst (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .events_i     (events_i),
        .xbar_sel_i   (xbar_sel),
        .selftest_i   (selftest),
        .cnt_events_o (cnt_events)
    );

    pmu_counters pmu_counters_inst (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .en_i         (cnt_en),
        .softrst_i    (cnt_softrst),
        .cnt_events_i (cnt_events),
        .load_i       (cnt_load),
        .load_idx_i   (cnt_load_idx),
        .load_val_i   (cnt_load_val),
        .cnt_values_o (cnt_values),
        .wrap_o       (wrap)
    );

    pmu_overflow pmu_overflow_inst (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .en_i            (ovf_en),
        .softrst_i       (ovf_softrst),
        .wrap_i          (wrap),
        .mask_i          (ovf_mask),
        .ovf_vect_o      (ovf_vect),
        .intr_overflow_o (intr_overflow_o)
    );

    pmu_quota pmu_quota_inst (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .softrst_i    (quota_softrst),
        .cnt_values_i (cnt_values),
        .mask_i       (quota_mask),
        .limit_i      (quota_limit),
        .intr_quota_o (intr_quota_o)
    );

endmodule

`default_nettype wire

// File: pmu_quota.sv
// Overall quota check; masked sum is wide enough not to wrap, interrupt is one cycle late
`default_nettype none
`timescale 1ns/1ps

`include "pmu_defines.svh"

module pmu_quota (
    input  wire                          clk_i,
    input  wire                          rstn_i,
    input  wire                          softrst_i,
    input  wire pmu_pkg::counter_array_t cnt_values_i,
    input  wire pmu_pkg::counter_mask_t  mask_i,
    input  wire pmu_pkg::reg_word_t      limit_i,
    output logic                         intr_quota_o
);

    // Room for N full counters
    localparam int SUM_W = `PMU_REG_WIDTH + $clog2(`PMU_N_COUNTERS);

    logic [SUM_W-1:0] sum;

    // ------------------------------
    // Masked adder tree
    // ------------------------------
    always_comb begin
        sum = '0;
        for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
            if (mask_i[k]) begin
                sum = sum + SUM_W'(cnt_values_i[k]);
            end
        end
    end

    // Strictly greater than limit
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            intr_quota_o <= 1'b0;
        end else if (softrst_i) begin
            intr_quota_o <= 1'b0;
        end else begin
            intr_quota_o <= sum > SUM_W'(limit_i);
        end
    end

endmodule

`default_nettype wire

// File: pmu_overflow.sv
// Sticky overflow vector; bits set on wrap regardless of enable, cleared by reset or soft reset
`default_nettype none
`timescale 1ns/1ps

module pmu_overflow (
    input  wire                         clk_i,
    input  wire                         rstn_i,
    input  wire                         en_i,
    input  wire                         softrst_i,
    input  wire pmu_pkg::counter_mask_t wrap_i,
    input  wire pmu_pkg::counter_mask_t mask_i,
    output pmu_pkg::counter_mask_t      ovf_vect_o,
    output logic                        intr_overflow_o
);

    pmu_pkg::counter_mask_t vect_q;

    // Accumulate wrap pulses until cleared
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            vect_q <= '0;
        end else if (softrst_i) begin
            vect_q <= '0;
        end else begin
            vect_q <= vect_q | wrap_i;
        end
    end

    assign ovf_vect_o = vect_q;

    // Any unmasked sticky bit, gated by enable
    assign intr_overflow_o = en_i && |(vect_q & mask_i);

endmodule

`default_nettype wire

// File: pmu_counters.sv
// Event counters; soft reset beats load, load beats increment, wrap_o is combinational
`default_nettype none
`timescale 1ns/1ps

`include "pmu_defines.svh"

module pmu_counters (
    input  wire                                clk_i,
    input  wire                                rstn_i,
    input  wire                                en_i,
    input  wire                                softrst_i,
    input  wire pmu_pkg::counter_mask_t        cnt_events_i,
    input  wire                                load_i,
    input  wire [$clog2(`PMU_N_COUNTERS)-1:0]  load_idx_i,
    input  wire pmu_pkg::reg_word_t            load_val_i,
    output pmu_pkg::counter_array_t            cnt_values_o,
    output pmu_pkg::counter_mask_t             wrap_o
);

    localparam int IDX_W = $clog2(`PMU_N_COUNTERS);

    pmu_pkg::counter_array_t cnt_q;
    pmu_pkg::counter_mask_t  hit;
    pmu_pkg::counter_mask_t  bump;

    // ------------------------------
    // Per-counter next-state terms
    // ------------------------------
    always_comb begin
        for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
            hit[k]    = load_i && (load_idx_i == IDX_W'(k));
            // Load wins over an event
            bump[k]   = en_i && cnt_events_i[k] && !hit[k];
            // All ones plus one, same edge as the increment
            wrap_o[k] = bump[k] && !softrst_i && (cnt_q[k] == '1);
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cnt_q <= '{default: '0};
        end else if (softrst_i) begin
            // Held at zero while soft reset is set
            cnt_q <= '{default: '0};
        end else begin
            for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
                if (hit[k]) begin
                    cnt_q[k] <= load_val_i;
                end else if (bump[k]) begin
                    cnt_q[k] <= cnt_q[k] + 1'b1;
                end
            end
        end
    end

    assign cnt_values_o = cnt_q;

endmodule

`default_nettype wire

// File: pmu_event_select.sv
// Event crossbar with self-test override; output is registered, so events lag one cycle
`default_nettype none
`timescale 1ns/1ps

`include "pmu_defines.svh"

module pmu_event_select (
    input  wire                     clk_i,
    input  wire                     rstn_i,
    input  wire pmu_pkg::soc_events_t events_i,
    input  wire pmu_pkg::xbar_sel_t   xbar_sel_i [`PMU_N_COUNTERS],
    input  wire pmu_pkg::selftest_e   selftest_i,
    output pmu_pkg::counter_mask_t  cnt_events_o
);

    pmu_pkg::counter_mask_t routed;
    pmu_pkg::counter_mask_t picked;

    // One mux per counter
    always_comb begin
        for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
            routed[k] = events_i[xbar_sel_i[k]];
        end
    end

    // Self-test replaces the routed events
    always_comb begin
        case (selftest_i)
            pmu_pkg::NO_SELF_TEST: picked = routed;
            pmu_pkg::ALL_ACTIVE:   picked = '1;
            pmu_pkg::ALL_OFF:      picked = '0;
            // Counter 0 only
            pmu_pkg::ONE_ON:       picked = pmu_pkg::counter_mask_t'(1);
            default:               picked = routed;
        endcase
    end

    // Capture stage ahead of the counters
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cnt_events_o <= '0;
        end else begin
            cnt_events_o <= picked;
        end
    end

endmodule

`default_nettype wire

// File: pmu_regs.sv
// PMU register file; single-cycle write strobe, combinational read, unmapped bits read zero
`default_nettype none
`timescale 1ns/1ps

`include "pmu_defines.svh"

module pmu_regs (
    input  wire                                   clk_i,
    input  wire                                   rstn_i,
    input  wire                                   reg_we_i,
    input  wire  [`PMU_ADDR_WIDTH-1:0]            reg_addr_i,
    input  wire  pmu_pkg::reg_word_t              reg_wdata_i,
    input  wire  pmu_pkg::counter_array_t         cnt_values_i,
    input  wire  pmu_pkg::counter_mask_t          ovf_vect_i,
    output pmu_pkg::reg_word_t                    reg_rdata_o,
    output logic                                  cnt_en_o,
    output logic                                  cnt_softrst_o,
    output logic                                  ovf_en_o,
    output logic                                  ovf_softrst_o,
    output logic                                  quota_softrst_o,
    output pmu_pkg::selftest_e                    selftest_o,
    output pmu_pkg::counter_mask_t                ovf_mask_o,
    output pmu_pkg::counter_mask_t                quota_mask_o,
    output pmu_pkg::reg_word_t                    quota_limit_o,
    output pmu_pkg::xbar_sel_t                    xbar_sel_o [`PMU_N_COUNTERS],
    output logic                                  cnt_load_o,
    output logic [$clog2(`PMU_N_COUNTERS)-1:0]    cnt_load_idx_o,
    output pmu_pkg::reg_word_t                    cnt_load_val_o
);

    localparam int IDX_W = $clog2(`PMU_N_COUNTERS);
    localparam int CNT_LAST = `PMU_ADDR_CNT_BASE + `PMU_N_COUNTERS - 1;

    // Only the defined configuration bits are kept
    localparam pmu_pkg::reg_word_t CFG_MASK =
        (32'd1 << `PMU_CFG_EN_BIT) |
        (32'd1 << `PMU_CFG_SOFTRST_BIT) |
        (32'd1 << `PMU_CFG_OVF_EN_BIT) |
        (32'd1 << `PMU_CFG_OVF_SOFTRST_BIT) |
        (32'd1 << `PMU_CFG_QUOTA_SOFTRST_BIT) |
        (32'd3 << `PMU_CFG_SELFTEST_LSB);

    pmu_pkg::reg_word_t     cfg_q;
    pmu_pkg::counter_mask_t ovf_mask_q;
    pmu_pkg::counter_mask_t quota_mask_q;
    pmu_pkg::reg_word_t     quota_limit_q;
    pmu_pkg::reg_word_t     xbar_q;
    logic                   cnt_hit;
    logic [IDX_W-1:0]       cnt_idx;

    // ------------------------------
    // Counter window decode
    // ------------------------------
    assign cnt_hit = (reg_addr_i >= `PMU_ADDR_CNT_BASE) && (reg_addr_i <= CNT_LAST);
    assign cnt_idx = IDX_W'(reg_addr_i - `PMU_ADDR_CNT_BASE);

    // Load lands in the counter on the write edge itself
    assign cnt_load_o     = reg_we_i && cnt_hit;
    assign cnt_load_idx_o = cnt_idx;
    assign cnt_load_val_o = reg_wdata_i;

    // ------------------------------
    // Write side
    // ------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cfg_q         <= '0;
            ovf_mask_q    <= '0;
            quota_mask_q  <= '0;
            quota_limit_q <= '0;
            xbar_q        <= '0;
        end else if (reg_we_i) begin
            case (reg_addr_i)
                `PMU_ADDR_CFG:         cfg_q         <= reg_wdata_i & CFG_MASK;
                `PMU_ADDR_OVF_MASK:    ovf_mask_q    <= reg_wdata_i[`PMU_N_COUNTERS-1:0];
                `PMU_ADDR_QUOTA_MASK:  quota_mask_q  <= reg_wdata_i[`PMU_N_COUNTERS-1:0];
                `PMU_ADDR_QUOTA_LIMIT: quota_limit_q <= reg_wdata_i;
                `PMU_ADDR_XBAR:        xbar_q        <= reg_wdata_i;
                // Counters, overflow vector and holes take nothing here
                default: ;
            endcase
        end
    end

    // Config levels out to the datapath
    assign cnt_en_o        = cfg_q[`PMU_CFG_EN_BIT];
    assign cnt_softrst_o   = cfg_q[`PMU_CFG_SOFTRST_BIT];
    assign ovf_en_o        = cfg_q[`PMU_CFG_OVF_EN_BIT];
    assign ovf_softrst_o   = cfg_q[`PMU_CFG_OVF_SOFTRST_BIT];
    assign quota_softrst_o = cfg_q[`PMU_CFG_QUOTA_SOFTRST_BIT];
    assign selftest_o      = pmu_pkg::selftest_e'(cfg_q[`PMU_CFG_SELFTEST_LSB +: 2]);
    assign ovf_mask_o      = ovf_mask_q;
    assign quota_mask_o    = quota_mask_q;
    assign quota_limit_o   = quota_limit_q;

    // Slice crossbar word into per-counter selects
    for (genvar k = 0; k < `PMU_N_COUNTERS; k++) begin : g_xbar
        assign xbar_sel_o[k] = xbar_q[k*`PMU_SEL_BITS +: `PMU_SEL_BITS];
    end

    // ------------------------------
    // Read mux
    // ------------------------------
    always_comb begin
        reg_rdata_o = '0;
        case (reg_addr_i)
            `PMU_ADDR_CFG:         reg_rdata_o = cfg_q;
            `PMU_ADDR_OVF_MASK:    reg_rdata_o = pmu_pkg::reg_word_t'(ovf_mask_q);
            `PMU_ADDR_OVF_VECT:    reg_rdata_o = pmu_pkg::reg_word_t'(ovf_vect_i);
            `PMU_ADDR_QUOTA_MASK:  reg_rdata_o = pmu_pkg::reg_word_t'(quota_mask_q);
            `PMU_ADDR_QUOTA_LIMIT: reg_rdata_o = quota_limit_q;
            `PMU_ADDR_XBAR:        reg_rdata_o = xbar_q;
            default: begin
                // Live counter values
                if (cnt_hit) begin
                    reg_rdata_o = cnt_values_i[cnt_idx];
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// File: pmu_pkg.sv
// Shared PMU types; sizes come from the defines header, self-test codes match config bits 31:30
`default_nettype none

`include "pmu_defines.svh"

package pmu_pkg;

    // One register word or counter value
    typedef logic [`PMU_REG_WIDTH-1:0] reg_word_t;

    // One bit per counter
    typedef logic [`PMU_N_COUNTERS-1:0] counter_mask_t;

    // Raw SoC event lines
    typedef logic [`PMU_N_SOC_EV-1:0] soc_events_t;

    // Crossbar select, picks one event line
    typedef logic [`PMU_SEL_BITS-1:0] xbar_sel_t;

    // Self-test modes
    typedef enum logic [1:0] {
        NO_SELF_TEST = 2'd0,
        ALL_ACTIVE   = 2'd1,
        ALL_OFF      = 2'd2,
        ONE_ON       = 2'd3
    } selftest_e;

    // All counter values side by side
    typedef reg_word_t counter_array_t [`PMU_N_COUNTERS];

endpackage

`default_nettype wire

// File: pmu_defines.svh
// PMU widths and register map; assumes 8 counters, 16 event lines and 4-bit selects
`ifndef PMU_DEFINES_SVH
`define PMU_DEFINES_SVH

// ------------------------------
// Sizes
// ------------------------------
`define PMU_REG_WIDTH 32
`define PMU_N_COUNTERS 8
`define PMU_N_SOC_EV 16
// Crossbar select field, log2 of event lines
`define PMU_SEL_BITS 4
`define PMU_ADDR_WIDTH 4

// ------------------------------
// Register map
// ------------------------------
`define PMU_ADDR_CFG 4'd0
// Counters sit at 1 to 8
`define PMU_ADDR_CNT_BASE 4'd1
`define PMU_ADDR_OVF_MASK 4'd9
// Read only
`define PMU_ADDR_OVF_VECT 4'd10
`define PMU_ADDR_QUOTA_MASK 4'd11
`define PMU_ADDR_QUOTA_LIMIT 4'd12
// Eight select fields, field k in bits 4k+3 to 4k
`define PMU_ADDR_XBAR 4'd13

// ------------------------------
// Configuration word bits
// ------------------------------
`define PMU_CFG_EN_BIT 0
`define PMU_CFG_SOFTRST_BIT 1
`define PMU_CFG_OVF_EN_BIT 2
`define PMU_CFG_OVF_SOFTRST_BIT 3
`define PMU_CFG_QUOTA_SOFTRST_BIT 4
// Two bits, 31 and 30
`define PMU_CFG_SELFTEST_LSB 30

`endif
